/* hw/link_settings.svh */
/* Link settings
   Sizes shared by the sample link RTL and its testbench */

`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

// ==================================================
// FIFO geometry
// ==================================================
`define FIFO_WIDTH    18            // One tagged beat per word
`define FIFO_DEPTH    8             // Power of 2, at least 4

// ==================================================
// Sample and frame fields
// ==================================================
`define SAMPLE_W      16            // Sample payload bits
`define FRAME_ID_W    8             // Frame ID, wraps
`define FRAME_LEN_W   9             // Samples per frame, up to 511

// Length limits applied by the config block
`define FRAME_LEN_MIN 1             // Zero length clamps to this
`define FRAME_LEN_RST 4             // Length out of reset

`endif

/* hw/linkPkg.sv */
/* Link word types
   Tagged FIFO beat, viewed either as a frame header or as a data sample */

`include "link_settings.svh"

package linkPkg;

    // Top bit of every FIFO word
    typedef enum logic {
        DATA   = 1'b0,                          // Sample beat
        HEADER = 1'b1                           // Frame start beat
    } beatTag_t;

    // Header view
    typedef struct packed {
        beatTag_t                 tag;          // Always HEADER
        logic [`FRAME_ID_W-1:0]   frameId;      // Base plus frame index
        logic [`FRAME_LEN_W-1:0]  frameLen;     // Expected sample count
    } headerBeat_t;

    // Data view
    typedef struct packed {
        beatTag_t                 tag;          // Always DATA
        logic                     rsvd;         // Written as zero
        logic [`SAMPLE_W-1:0]     sample;       // Payload
    } dataBeat_t;

    // One word, two decodes, tag shared in the MSB
    typedef union packed {
        headerBeat_t              hdr;
        dataBeat_t                dat;
    } fifoWord_t;

endpackage

/* hw/regPkg.sv */
/* Config register map
   Addresses and field positions of the write-side register block */

package regPkg;

    // ==================================================
    // Register addresses
    // ==================================================
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,                      // Enable bit
        REG_LEN    = 2'd1,                      // Frame length in samples
        REG_IDBASE = 2'd2                       // First frame ID
    } cfgAddr_t;

    // Write data bus
    typedef logic [15:0] cfgData_t;

    // ==================================================
    // Field positions within cfgData
    // ==================================================
    localparam int CtrlEnBit = 0;               // REG_CTRL enable
    localparam int LenLsb    = 0;               // REG_LEN field start
    localparam int IdBaseLsb = 0;               // REG_IDBASE field start

endpackage

/* hw/asyncFifo.sv */
/* Dual-clock FIFO
   Gray pointers, direction latch, and synchronized rok/wok levels */

`timescale 1ns/10ps

`include "link_settings.svh"

module asyncFifo #(
    parameter int Width = `FIFO_WIDTH,
    parameter int Size  = `FIFO_DEPTH           // Power of 2, at least 4
) (
    input  logic             rclk,              // Read clock
    input  logic             r,                 // Read trigger
    output logic [Width-1:0] rd,                // Oldest word
    output logic             rok,               // Not empty
    input  logic             wclk,              // Write clock
    input  logic             w,                 // Write trigger
    input  logic [Width-1:0] wd,                // Write data
    output logic             wok,               // Not full
    input  logic             arok               // Async reset, active low
);
    localparam int N = $clog2(Size) - 1;        // Pointer MSB

    logic [Width-1:0] mem [Size];
    logic [N:0] rbAddr, rgAddr, rbNext;         // Read pointer, binary and Gray
    logic [N:0] wbAddr, wgAddr, wbNext;         // Write pointer, binary and Gray
    logic [1:0] rokSync, wokSync;
    logic       rokClrN, wokClrN;
    logic       dir, dirSet, dirClr;
    logic       notEmptyAsync, notFullAsync;

    // ==================================================
    // Read side
    // ==================================================
    assign rbNext = rbAddr + 1'b1;

    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            rbAddr <= '0;
            rgAddr <= '0;
        end else if (r && rok) begin
            rbAddr <= rbNext;
            rgAddr <= rbNext ^ (rbNext >> 1);   // Binary to Gray
        end
    end

    assign rd = mem[rbAddr];                    // Show-ahead

    assign rokClrN = arok & notEmptyAsync;      // Empty drops rok at once
    always_ff @(posedge rclk or negedge rokClrN) begin
        if (!rokClrN) rokSync <= '0;
        else          rokSync <= {rokSync[0], 1'b1};
    end
    assign rok = rokSync[1];

    // ==================================================
    // Write side
    // ==================================================
    assign wbNext = wbAddr + 1'b1;

    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            wbAddr <= '0;
            wgAddr <= '0;
        end else if (w && wok) begin
            wbAddr <= wbNext;
            wgAddr <= wbNext ^ (wbNext >> 1);
        end
    end

    always_ff @(posedge wclk) begin
        if (w && wok) mem[wbAddr] <= wd;        // Storage, no reset
    end

    assign wokClrN = arok & notFullAsync;       // Full drops wok at once
    always_ff @(posedge wclk or negedge wokClrN) begin
        if (!wokClrN) wokSync <= '0;
        else          wokSync <= {wokSync[0], 1'b1};
    end
    assign wok = wokSync[1];

    // ==================================================
    // Full/empty from pointer quadrants
    // ==================================================
    // Writer one quadrant behind reader, so heading full
    assign dirSet = (rgAddr[N] == wgAddr[N-1]) & (rgAddr[N-1] != wgAddr[N]);
    // Writer one quadrant ahead of reader, so heading empty
    assign dirClr = ((rgAddr[N] != wgAddr[N-1]) & (rgAddr[N-1] == wgAddr[N])) | ~arok;

    always_ff @(posedge dirSet or posedge dirClr) begin
        if (dirClr) dir <= 1'b0;
        else        dir <= 1'b1;
    end

    assign notEmptyAsync = !((rgAddr == wgAddr) && !dir);
    assign notFullAsync  = !((rgAddr == wgAddr) && dir);

endmodule

/* hw/frameConfig.sv */
/* Frame config registers
   Write-only enable, frame length and frame ID base in the write domain */

`timescale 1ns/10ps

`include "link_settings.svh"

module frameConfig (
    input  logic                    wclk,
    input  logic                    arok,           // Async reset, active low
    input  logic                    cfgWr,          // Write strobe
    input  regPkg::cfgAddr_t        cfgAddr,
    input  regPkg::cfgData_t        cfgData,
    output logic                    cfgEnable,      // Packer on
    output logic [`FRAME_LEN_W-1:0] cfgFrameLen,    // Samples per frame
    output logic [`FRAME_ID_W-1:0]  cfgIdBase       // First frame ID
);
    localparam logic [`FRAME_LEN_W-1:0] MinLen = `FRAME_LEN_MIN;
    localparam logic [`FRAME_LEN_W-1:0] RstLen = `FRAME_LEN_RST;

    logic [`FRAME_LEN_W-1:0] lenField;
    logic [`FRAME_ID_W-1:0]  idField;

    // ==================================================
    // Field extraction
    // ==================================================
    assign lenField = cfgData[regPkg::LenLsb +: `FRAME_LEN_W];
    assign idField  = cfgData[regPkg::IdBaseLsb +: `FRAME_ID_W];

    // ==================================================
    // Register writes
    // ==================================================
    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            cfgEnable   <= 1'b0;                        // Off until written
            cfgFrameLen <= RstLen;
            cfgIdBase   <= '0;
        end else if (cfgWr) begin
            case (cfgAddr)
                regPkg::REG_CTRL: begin
                    cfgEnable <= cfgData[regPkg::CtrlEnBit];
                end
                regPkg::REG_LEN: begin
                    // Zero length would never close a frame
                    cfgFrameLen <= (lenField == '0) ? MinLen : lenField;
                end
                regPkg::REG_IDBASE: begin
                    cfgIdBase <= idField;
                end
                default: begin
                    // Unmapped address, nothing stored
                end
            endcase
        end
    end

endmodule

/* hw/framePacker.sv */
/* Frame packer
   Turns frame starts and samples into tagged FIFO words, dropping on full */

`timescale 1ns/10ps

`include "link_settings.svh"

module framePacker (
    input  logic                    wclk,
    input  logic                    arok,           // Async reset, active low
    input  logic                    cfgEnable,
    input  logic [`FRAME_LEN_W-1:0] cfgFrameLen,
    input  logic [`FRAME_ID_W-1:0]  cfgIdBase,
    input  logic                    frameStart,     // One-cycle pulse
    input  logic                    sampleValid,    // One-cycle strobe
    input  logic [`SAMPLE_W-1:0]    sampleIn,
    input  logic                    fifoWok,        // FIFO has room
    output logic                    fifoW,          // FIFO write trigger
    output linkPkg::fifoWord_t      fifoWd,         // FIFO write word
    output logic                    sampleDrop      // Sample not written
);
    logic                   hdrReq;                 // Header wanted this cycle
    logic                   datReq;                 // Data beat wanted this cycle
    logic [`FRAME_ID_W-1:0] frameCnt;               // Frames started since reset

    // ==================================================
    // Request decode
    // ==================================================
    assign hdrReq = cfgEnable & frameStart;
    assign datReq = cfgEnable & sampleValid & ~frameStart;  // Header wins a collision

    assign fifoW = hdrReq | datReq;                 // FIFO ignores it when full

    // Any sample that does not land in the FIFO is reported
    assign sampleDrop = sampleValid & ~(datReq & fifoWok);

    // ==================================================
    // Word build
    // ==================================================
    always_comb begin
        fifoWd = '0;
        if (frameStart) begin
            fifoWd.hdr.tag      = linkPkg::HEADER;
            fifoWd.hdr.frameId  = cfgIdBase + frameCnt;     // Wraps at 8 bits
            fifoWd.hdr.frameLen = cfgFrameLen;              // Length at frame start
        end else begin
            fifoWd.dat.tag      = linkPkg::DATA;
            fifoWd.dat.rsvd     = 1'b0;
            fifoWd.dat.sample   = sampleIn;
        end
    end

    // ==================================================
    // Frame counter
    // ==================================================
    // Counts every enabled frame start, dropped headers too,
    // so later IDs still match the frame index
    always_ff @(posedge wclk or negedge arok) begin
        if (!arok) begin
            frameCnt <= '0;
        end else if (hdrReq) begin
            frameCnt <= frameCnt + 1'b1;
        end
    end

endmodule

/* hw/frameUnpacker.sv */
/* Frame unpacker
   Drains the FIFO, splits headers from samples and checks frame lengths */

`timescale 1ns/10ps

`include "link_settings.svh"

module frameUnpacker (
    input  logic                    rclk,
    input  logic                    arok,           // Async reset, active low
    input  logic                    rdHold,         // Stop draining
    input  logic                    fifoRok,        // FIFO not empty
    input  linkPkg::fifoWord_t      fifoRd,         // Oldest FIFO word
    output logic                    fifoR,          // FIFO read trigger
    output logic                    outValid,       // Sample pulse
    output logic [`SAMPLE_W-1:0]    outSample,
    output logic                    outFrameStart,  // Header pulse
    output logic [`FRAME_ID_W-1:0]  outFrameId,
    output logic                    lengthErr       // Previous frame count wrong
);
    localparam int CntW = `FRAME_LEN_W + 1;         // Room to see overruns

    linkPkg::beatTag_t       rdTag;
    logic                    isHdr;
    logic                    seenHdr;               // A header has arrived
    logic [`FRAME_LEN_W-1:0] curLen;                // Length of open frame
    logic [CntW-1:0]         beatCnt;               // Data beats in open frame
    logic                    lenMismatch;

    // ==================================================
    // Read and decode
    // ==================================================
    assign fifoR = fifoRok & ~rdHold;               // Drain whenever allowed

    assign rdTag = fifoRd.hdr.tag;                  // Same bit in either view
    assign isHdr = (rdTag == linkPkg::HEADER);

    // Count vs header length, only once a frame is open
    assign lenMismatch = seenHdr & (beatCnt != {1'b0, curLen});

    // ==================================================
    // Control and check
    // ==================================================
    always_ff @(posedge rclk or negedge arok) begin
        if (!arok) begin
            outValid      <= 1'b0;
            outFrameStart <= 1'b0;
            lengthErr     <= 1'b0;
            seenHdr       <= 1'b0;
            curLen        <= '0;
            beatCnt       <= '0;
        end else begin
            outValid      <= fifoR & ~isHdr;
            outFrameStart <= fifoR & isHdr;
            lengthErr     <= fifoR & isHdr & lenMismatch;   // Checked at next header
            if (fifoR) begin
                if (isHdr) begin
                    seenHdr <= 1'b1;
                    curLen  <= fifoRd.hdr.frameLen;         // Open new frame
                    beatCnt <= '0;
                end else if (seenHdr && (beatCnt != '1)) begin
                    beatCnt <= beatCnt + 1'b1;              // Saturates
                end
            end
        end
    end

    // ==================================================
    // Payload
    // ==================================================
    always_ff @(posedge rclk) begin
        if (fifoR) begin
            if (isHdr) outFrameId <= fifoRd.hdr.frameId;
            else       outSample  <= fifoRd.dat.sample;
        end
    end

endmodule

/* hw/cdcLinkTop.sv */
/* Sample link top
   Config and packer on wclk, async FIFO, unpacker on rclk */

`timescale 1ns/10ps

`include "link_settings.svh"

module cdcLinkTop (
    input  logic                    wclk,           // Write domain clock
    input  logic                    rclk,           // Read domain clock
    input  logic                    arok,           // Async reset, both domains
    // Write domain
    input  logic                    cfgWr,
    input  regPkg::cfgAddr_t        cfgAddr,
    input  regPkg::cfgData_t        cfgData,
    input  logic                    frameStart,
    input  logic                    sampleValid,
    input  logic [`SAMPLE_W-1:0]    sampleIn,
    output logic                    sampleDrop,
    // Read domain
    input  logic                    rdHold,
    output logic                    outValid,
    output logic [`SAMPLE_W-1:0]    outSample,
    output logic                    outFrameStart,
    output logic [`FRAME_ID_W-1:0]  outFrameId,
    output logic                    lengthErr
);
    logic                    cfgEnable;
    logic [`FRAME_LEN_W-1:0] cfgFrameLen;
    logic [`FRAME_ID_W-1:0]  cfgIdBase;
    logic                    fifoW, fifoWok;        // Write side of FIFO
    linkPkg::fifoWord_t      fifoWd;
    logic                    fifoR, fifoRok;        // Read side of FIFO
    linkPkg::fifoWord_t      fifoRd;

    // ==================================================
    // Write domain
    // ==================================================
    frameConfig frameConfig_i (
        .wclk(wclk), .arok(arok),
        .cfgWr(cfgWr), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .cfgEnable(cfgEnable), .cfgFrameLen(cfgFrameLen), .cfgIdBase(cfgIdBase)
    );

    framePacker framePacker_i (
        .wclk(wclk), .arok(arok),
        .cfgEnable(cfgEnable), .cfgFrameLen(cfgFrameLen), .cfgIdBase(cfgIdBase),
        .frameStart(frameStart), .sampleValid(sampleValid), .sampleIn(sampleIn),
        .fifoWok(fifoWok), .fifoW(fifoW), .fifoWd(fifoWd), .sampleDrop(sampleDrop)
    );

    // ==================================================
    // Crossing
    // ==================================================
    asyncFifo #(
        .Width(`FIFO_WIDTH),                        // Matches fifoWord_t
        .Size (`FIFO_DEPTH)
    ) asyncFifo_i (
        .rclk(rclk), .r(fifoR), .rd(fifoRd), .rok(fifoRok),
        .wclk(wclk), .w(fifoW), .wd(fifoWd), .wok(fifoWok),
        .arok(arok)
    );

    // ==================================================
    // Read domain
    // ==================================================
    frameUnpacker frameUnpacker_i (
        .rclk(rclk), .arok(arok), .rdHold(rdHold),
        .fifoRok(fifoRok), .fifoRd(fifoRd), .fifoR(fifoR),
        .outValid(outValid), .outSample(outSample),
        .outFrameStart(outFrameStart), .outFrameId(outFrameId),
        .lengthErr(lengthErr)
    );

endmodule

/* bench/cdcLink_props.sv */
/* Async FIFO properties
   Pointer, level and show-ahead checks bound into every asyncFifo */

`timescale 1ns/10ps

`include "link_settings.svh"

module cdcLinkProps #(
    parameter int Width = `FIFO_WIDTH,
    parameter int N     = $clog2(`FIFO_DEPTH) - 1   // Pointer MSB
) (
    input logic             rclk,
    input logic             wclk,
    input logic             arok,
    input logic             r,
    input logic             rok,
    input logic             w,
    input logic             wok,
    input logic [Width-1:0] rd,
    input logic [N:0]       rbAddr,
    input logic [N:0]       wbAddr
);
    // ==================================================
    // Pointer moves only when allowed
    // ==================================================
    assert property (@(posedge wclk) disable iff (!arok) !wok |=> $stable(wbAddr))
        else $error("write pointer moved while wok was low");

    assert property (@(posedge rclk) disable iff (!arok) !rok |=> $stable(rbAddr))
        else $error("read pointer moved while rok was low");

    // ==================================================
    // Levels and show-ahead word
    // ==================================================
    assert property (@(posedge rclk) $rose(arok) |-> !rok)       // First edge out of reset
        else $error("rok high in the first cycle after reset");

    assert property (@(posedge rclk) disable iff (!arok) (rok && !r) |=> $stable(rd))
        else $error("rd changed while rok was high and no read was made");

endmodule

bind asyncFifo cdcLinkProps #(
    .Width(Width),
    .N    (N)
) asyncFifoProps_i (
    .rclk(rclk), .wclk(wclk), .arok(arok),
    .r(r), .rok(rok), .w(w), .wok(wok),
    .rd(rd), .rbAddr(rbAddr), .wbAddr(wbAddr)
);

/* bench/cdcLinkTb.sv */
/* Sample link testbench
   Vector-driven stimulus, queue reference model, output compare and watchdog */

`timescale 1ns/10ps

`include "link_settings.svh"

module cdcLinkTb;
    localparam int RclkPeriod = 40;
    localparam int WclkPeriod = 28;
    localparam logic [`FRAME_LEN_W-1:0] OneLen = 1;     // Zero length clamps here

    typedef struct packed {
        logic               lenErr;                     // lengthErr due with this beat
        linkPkg::fifoWord_t word;
    } expBeat_t;

    logic                    rclk = 1'b0;
    logic                    wclk = 1'b0;
    logic                    arok;
    logic                    cfgWr, frameStart, sampleValid, rdHold;
    regPkg::cfgAddr_t        cfgAddr;
    regPkg::cfgData_t        cfgData;
    logic [`SAMPLE_W-1:0]    sampleIn, outSample;
    logic                    sampleDrop, outValid, outFrameStart, lengthErr;
    logic [`FRAME_ID_W-1:0]  outFrameId;

    // ==================================================
    // Reference model state
    // ==================================================
    expBeat_t                expQ[$];                   // Words the FIFO accepted
    string                   testName = "reset";
    int                      valueErrs = 0;
    int                      otherErrs = 0;
    int                      vecCount = 0;
    logic                    enM = 1'b0;
    logic                    seenHdrM = 1'b0;
    logic                    holdM = 1'b0;
    logic [`FRAME_LEN_W-1:0] lenM = `FRAME_LEN_RST;
    logic [`FRAME_LEN_W-1:0] hdrLenM = '0;              // Length of open frame
    logic [`FRAME_ID_W-1:0]  idBaseM = '0;
    logic [`FRAME_ID_W-1:0]  frameCntM = '0;
    int                      cntM = 0;                  // Samples in open frame
    int                      heldWords = 0;
    int                      heldTries = 0;
    int                      heldDrops = 0;

    always #(RclkPeriod / 2) rclk = ~rclk;
    always #(WclkPeriod / 2) wclk = ~wclk;

    cdcLinkTop cdcLinkTop_i (
        .wclk(wclk), .rclk(rclk), .arok(arok),
        .cfgWr(cfgWr), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .frameStart(frameStart), .sampleValid(sampleValid), .sampleIn(sampleIn),
        .sampleDrop(sampleDrop), .rdHold(rdHold),
        .outValid(outValid), .outSample(outSample),
        .outFrameStart(outFrameStart), .outFrameId(outFrameId), .lengthErr(lengthErr)
    );

    // ==================================================
    // Compare and report
    // ==================================================
    task automatic checkSample(input string name, input logic [`SAMPLE_W-1:0] want, got);
        if (got !== want) begin
            valueErrs++;
            $display("ERR %s: expected %h, got %h", name, want, got);
        end
    endtask

    task automatic checkFrameId(input string name, input logic [`FRAME_ID_W-1:0] want, got);
        if (got !== want) begin
            valueErrs++;
            $display("ERR %s: expected %h, got %h", name, want, got);
        end
    endtask

    task automatic checkFlag(input string name, input logic want, got);
        if (got !== want) begin
            valueErrs++;
            $display("ERR %s: expected %b, got %b", name, want, got);
        end
    endtask

    task automatic reportErr(input string what);
        otherErrs++;
        $display("Failure in %s: %s", testName, what);
    endtask

    // ==================================================
    // Model updates
    // ==================================================
    task automatic pushHeader();
        expBeat_t e;
        e                   = '0;
        e.word.hdr.tag      = linkPkg::HEADER;
        e.word.hdr.frameId  = idBaseM + frameCntM;      // Wraps at 8 bits
        e.word.hdr.frameLen = lenM;
        e.lenErr            = seenHdrM && (cntM != int'(hdrLenM));
        expQ.push_back(e);
        frameCntM++;
        hdrLenM  = lenM;
        cntM     = 0;
        seenHdrM = 1'b1;
        if (holdM) heldWords++;
    endtask

    task automatic pushData(input logic [`SAMPLE_W-1:0] v);
        expBeat_t e;
        e                 = '0;
        e.word.dat.tag    = linkPkg::DATA;
        e.word.dat.sample = v;
        expQ.push_back(e);
        if (seenHdrM) cntM++;                           // No check before first header
        if (holdM) heldWords++;
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic writeReg(input logic [1:0] a, input regPkg::cfgData_t d);
        @(posedge wclk);
        cfgWr   <= 1'b1;
        cfgAddr <= regPkg::cfgAddr_t'(a);
        cfgData <= d;
        @(posedge wclk);
        cfgWr   <= 1'b0;
        case (a)
            regPkg::REG_CTRL:   enM = d[0];
            regPkg::REG_LEN:    lenM = (d[`FRAME_LEN_W-1:0] == '0) ? OneLen : d[`FRAME_LEN_W-1:0];
            regPkg::REG_IDBASE: idBaseM = d[`FRAME_ID_W-1:0];
            default:            ;                       // Unmapped, no effect
        endcase
    endtask

    task automatic writeBeat(input logic start, input logic valid, input logic [`SAMPLE_W-1:0] v);
        logic wantDrop;
        @(posedge wclk);
        frameStart  <= start;
        sampleValid <= valid;
        sampleIn    <= v;
        @(negedge wclk);                                // Drop is combinational
        if (start && enM) pushHeader();
        if (holdM && (start || valid)) heldTries++;
        if (valid) begin
            wantDrop = !enM || start;                   // Off, or colliding with a header
            // FIFO only fills while reads are held
            if (wantDrop || !holdM) begin
                checkFlag({testName, " sampleDrop"}, wantDrop, sampleDrop);
            end
            if (!wantDrop && !sampleDrop) pushData(v);
            if (holdM && sampleDrop) heldDrops++;
        end else begin
            checkFlag({testName, " sampleDrop on header"}, 1'b0, sampleDrop);
        end
        @(posedge wclk);
        frameStart  <= 1'b0;
        sampleValid <= 1'b0;
    endtask

    task automatic setHold(input logic level);
        @(posedge rclk);
        rdHold <= level;
        if (level) begin
            holdM     = 1'b1;
            heldWords = 0;
            heldTries = 0;
            heldDrops = 0;
        end else begin
            holdM = 1'b0;
            if (heldWords > `FIFO_DEPTH) reportErr("FIFO took more words than it holds");
            if (heldTries > `FIFO_DEPTH && heldDrops == 0) reportErr("no drop while held full");
        end
    endtask

    // ==================================================
    // Read-side monitor
    // ==================================================
    always @(negedge rclk) begin
        expBeat_t e;
        if (arok) begin
            if (outValid && outFrameStart) begin
                reportErr("sample and frame start in the same cycle");
            end else if (outValid || outFrameStart) begin
                if (expQ.size() == 0) begin
                    reportErr("output appeared with nothing expected");
                end else begin
                    e = expQ.pop_front();
                    if (outFrameStart != (e.word.hdr.tag == linkPkg::HEADER)) begin
                        reportErr("header and sample order differs from what was written");
                    end else if (outFrameStart) begin
                        checkFrameId({testName, " frameId"}, e.word.hdr.frameId, outFrameId);
                        checkFlag({testName, " lengthErr"}, e.lenErr, lengthErr);
                    end else begin
                        checkSample({testName, " sample"}, e.word.dat.sample, outSample);
                        checkFlag({testName, " lengthErr on sample"}, 1'b0, lengthErr);
                    end
                end
            end else begin
                checkFlag({testName, " lengthErr idle"}, 1'b0, lengthErr);
            end
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int          fd;
        int          c;
        int          n;
        int          num;
        string       cmd;
        logic [15:0] a;
        logic [15:0] d;
        arok        = 1'b0;
        cfgWr       = 1'b0;
        cfgAddr     = regPkg::REG_CTRL;
        cfgData     = '0;
        frameStart  = 1'b0;
        sampleValid = 1'b0;
        sampleIn    = '0;
        rdHold      = 1'b0;
        void'($urandom(72834));
        fd = $fopen("bench/link_vectors.txt", "r");
        if (fd == 0) reportErr("cannot open bench/link_vectors.txt");
        while (fd != 0 && !$feof(fd)) begin            // Size the watchdog
            c = $fgetc(fd);
            if (c == "\n") vecCount++;
        end
        if (fd != 0) begin
            $fclose(fd);
            fd = $fopen("bench/link_vectors.txt", "r");
        end
        repeat (4) @(posedge rclk);
        #7 arok = 1'b1;                                 // Off both clock edges
        repeat (2) @(posedge wclk);
        while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.getc(0) == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) c = $fgetc(fd);
            end else if (cmd == "test") begin
                n = $fscanf(fd, "%s", testName);
                if (n != 1) reportErr("test line without a name");
            end else if (cmd == "cfg") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) reportErr("cfg line without address and data");
                writeReg(a[1:0], d);
            end else if (cmd == "start") begin
                writeBeat(1'b1, 1'b0, '0);
            end else if (cmd == "sample" || cmd == "collide") begin
                n = $fscanf(fd, "%h", d);
                if (n != 1) reportErr({cmd, " line without a value"});
                writeBeat(cmd == "collide", 1'b1, d);
                repeat ($urandom % 3) @(posedge wclk);  // Random gap
            end else if (cmd == "hold") begin
                n = $fscanf(fd, "%d", num);
                if (n != 1) reportErr("hold line without a level");
                setHold(num[0]);
            end else if (cmd == "idle") begin
                n = $fscanf(fd, "%d", num);
                if (n != 1) reportErr("idle line without a count");
                repeat (num) @(posedge wclk);
            end else begin
                reportErr({"unknown vector command ", cmd});
            end
        end
        if (fd != 0) $fclose(fd);
        num = 0;
        while (expQ.size() != 0 && num < 400) begin
            @(posedge rclk);
            num++;
        end
        repeat (10) @(posedge rclk);                    // Catch extra outputs
        if (expQ.size() != 0) reportErr($sformatf("%0d outputs never appeared", expQ.size()));
        $display("Errors: %0d wrong values, %0d other failures", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        @(posedge arok);
        #(vecCount * 20 * RclkPeriod + 2000);
        $display("Watchdog expired before the vectors finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* bench/link_vectors.txt */
# cfg <addr hex> <data hex> | start | sample <hex> | collide <hex> (start plus sample)
# hold <0|1> | idle <wclk cycles> | test <name>
test preEnable
start
sample 0BAD
idle 10
test config
cfg 1 0003
cfg 2 00FE
cfg 3 0055
cfg 0 0001
test ordering
start
sample 1111
sample 2222
sample 3333
start
sample 4444
sample 5555
sample 6666
test lengthShort
start
sample 7001
sample 7002
test lengthLong
start
sample 7101
sample 7102
sample 7103
sample 7104
test collision
collide 0C0C
sample 7201
sample 7202
sample 7203
test backPressure
idle 12
hold 1
start
sample A001
sample A002
sample A003
sample A004
sample A005
sample A006
sample A007
sample A008
sample A009
sample A00A
hold 0
idle 20
test lengthDrop
cfg 1 0000
start
sample B001
start
sample B101
sample B102
start
idle 10

/* files.f */
+incdir+hw
hw/linkPkg.sv
hw/regPkg.sv
hw/asyncFifo.sv
hw/frameConfig.sv
hw/framePacker.sv
hw/frameUnpacker.sv
hw/cdcLinkTop.sv
bench/cdcLink_props.sv
bench/cdcLinkTb.sv

/* run_sim.sh */
#!/bin/sh
# Build the sample link testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module cdcLinkTb -o cdcLinkSim &&
./obj_dir/cdcLinkSim | tee /dev/stderr | grep -q "^STATUS: PASS$" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
